// ==== fsq.f ====
+incdir+bench
common/fsqPkg.sv
fsq/fsqPointers.sv
fsq/streamStore.sv
fsq/fetchIssue.sv
fsq/commitTracker.sv
src/fsqTop.sv
bench/fsqTb.sv

// ==== bench/fsqTests.svh ====
// pointer for the n-th stream since reset
function automatic fsqPkg::fsqPtrT ptrAt(input int n);
    fsqPkg::fsqPtrT p;
    p.idx = fsqPkg::fsqWidth'(n % fsqPkg::fsqSize);
    p.dir = ((n / fsqPkg::fsqSize) % 2) == 1;
    return p;
endfunction

function automatic fsqPkg::fsqPtrT advancePtr(input fsqPkg::fsqPtrT p);
    fsqPkg::fsqPtrT n;
    n = p;
    if (p.idx == fsqPkg::fsqWidth'(fsqPkg::fsqSize - 1)) begin
        n.idx = '0;
        n.dir = ~p.dir;
    end else begin
        n.idx = p.idx + 1'b1;
    end
    return n;
endfunction

function automatic fsqPkg::fetchStreamT randomStream(input int minSize);
    fsqPkg::fetchStreamT s;
    s.startAddr = $urandom;
    s.size = fsqPkg::offsetWidth'(minSize + ($urandom % (fsqPkg::blockInstSize - minSize)));
    return s;
endfunction

// drive tasks end on the falling edge so outputs can be checked
task automatic enqueueStream(input fsqPkg::fetchStreamT s);
    @(posedge clk);
    predict <= '{en: 1'b1, stream: s};
    @(negedge clk);
endtask

task automatic idleCycle();
    @(posedge clk);
    predict.en <= 1'b0;
    pdRedirect.en <= 1'b0;
    beRedirect.en <= 1'b0;
    commitBus <= '0;
    @(negedge clk);
endtask

// negative offset leaves the lane off
task automatic driveCommit(input fsqPkg::fsqPtrT ptr, input int offA, input int offB);
    fsqPkg::commitSlotT [fsqPkg::commitWidth-1:0] lanes;
    lanes = '0;
    lanes[0].en = (offA >= 0);
    lanes[0].fsqInfo.ptr = ptr;
    lanes[0].fsqInfo.offset = fsqPkg::offsetWidth'(offA);
    lanes[1].en = (offB >= 0);
    lanes[1].fsqInfo.ptr = ptr;
    lanes[1].fsqInfo.offset = fsqPkg::offsetWidth'(offB);
    @(posedge clk);
    predict.en <= 1'b0;
    commitBus <= lanes;
    @(negedge clk);
endtask

task automatic inOrderIssue();
    fsqPkg::fetchStreamT sent [6];
    fsqPkg::cacheReqT exp;
    int got;
    applyReset();
    for (int i = 0; i < 6; i++) begin
        sent[i] = randomStream(0);
    end
    got = 0;
    for (int c = 0; c < 20; c++) begin
        @(posedge clk);
        if (c < 6) begin
            predict <= '{en: 1'b1, stream: sent[c]};
        end else begin
            predict.en <= 1'b0;
        end
        @(negedge clk);
        if (cacheReq.valid === 1'b1) begin
            if (got < 6) begin
                exp = '{valid: 1'b1, ptr: ptrAt(got), stream: sent[got]};
                checkCacheReq(cacheReq, exp, "in-order issue");
            end
            got++;
        end
    end
    checks++;
    if (got != 6) begin
        errors++;
        $display("CHECK FAILED at %0t: in-order issue, saw %0d cache requests for 6 streams",
                 $time, got);
    end
endtask

task automatic fullAndBackPressure();
    fsqPkg::fetchStreamT sent [fsqPkg::fsqSize];
    fsqPkg::cacheReqT held;
    fsqPkg::cacheReqT exp;
    applyReset();
    for (int i = 0; i < fsqPkg::fsqSize; i++) begin
        sent[i] = randomStream(0);
    end
    held = '{valid: 1'b1, ptr: ptrAt(0), stream: sent[0]};
    for (int i = 0; i < fsqPkg::fsqSize; i++) begin
        @(posedge clk);
        predict <= '{en: 1'b1, stream: sent[i]};
        // stream 0 gets out before the buffer fills
        if (i == 2) begin
            ibufFull <= 1'b1;
        end
        @(negedge clk);
        checkBit(predStall, 1'b0, "predStall before queue is full");
        if (i >= 2) begin
            checkCacheReq(cacheReq, held, "cacheReq held while ibufFull");
        end
    end
    enqueueStream(randomStream(0));
    checkBit(predStall, 1'b1, "predStall after sixteenth enqueue");
    checkPtr(tailPtr, ptrAt(fsqPkg::fsqSize), "tailPtr when full");
    idleCycle();
    checkPtr(tailPtr, ptrAt(fsqPkg::fsqSize), "tailPtr after enqueue while full");
    checkCacheReq(cacheReq, held, "cacheReq held while ibufFull");
    @(posedge clk);
    ibufFull <= 1'b0;
    @(negedge clk);
    idleCycle();
    exp = '{valid: 1'b1, ptr: ptrAt(1), stream: sent[1]};
    checkCacheReq(cacheReq, exp, "issue resumes after ibufFull release");
    // stream 2 is taken at this edge, then the cache stops accepting
    @(posedge clk);
    cacheReady <= 1'b0;
    @(negedge clk);
    idleCycle();
    exp = '{valid: 1'b1, ptr: ptrAt(2), stream: sent[2]};
    checkCacheReq(cacheReq, exp, "cacheReq held while cache not ready");
    @(posedge clk);
    cacheReady <= 1'b1;
    @(negedge clk);
    idleCycle();
    exp = '{valid: 1'b1, ptr: ptrAt(3), stream: sent[3]};
    checkCacheReq(cacheReq, exp, "issue resumes after cache ready");
endtask

task automatic predecodeRedirect();
    fsqPkg::redirectT rd;
    fsqPkg::squashT exp;
    applyReset();
    for (int i = 0; i < 3; i++) begin
        enqueueStream(randomStream(0));
    end
    rd = '0;
    rd.en = 1'b1;
    rd.fsqInfo.ptr = ptrAt(1);
    rd.fsqInfo.offset = 3'd2;
    for (int pass = 0; pass < 2; pass++) begin
        rd.target = $urandom;
        // second pass lands on the last slot so the tail wraps
        if (pass == 1) begin
            rd.fsqInfo.ptr = ptrAt(fsqPkg::fsqSize - 1);
        end
        @(posedge clk);
        predict.en <= 1'b0;
        pdRedirect <= rd;
        @(negedge clk);
        checkBit(cacheFlush, 1'b1, "cacheFlush in predecode redirect cycle");
        checkBit(squash.en, 1'b0, "squash before redirect edge");
        idleCycle();
        exp = '{en: 1'b1, target: rd.target};
        checkSquash(squash, exp, "squash after predecode redirect");
        checkPtr(tailPtr, advancePtr(rd.fsqInfo.ptr), "tailPtr after predecode redirect");
        checkBit(cacheFlush, 1'b0, "cacheFlush after redirect");
        idleCycle();
        checkBit(squash.en, 1'b0, "squash is a single pulse");
    end
endtask

task automatic redirectPriority();
    fsqPkg::redirectT pd;
    fsqPkg::redirectT be;
    fsqPkg::squashT exp;
    applyReset();
    for (int i = 0; i < 4; i++) begin
        enqueueStream(randomStream(0));
    end
    pd = '0;
    pd.en = 1'b1;
    pd.fsqInfo.ptr = ptrAt(3);
    pd.target = $urandom;
    be = '0;
    be.en = 1'b1;
    be.fsqInfo.ptr = ptrAt(1);
    be.fsqInfo.offset = fsqPkg::offsetWidth'($urandom);
    be.target = $urandom;
    @(posedge clk);
    predict.en <= 1'b0;
    pdRedirect <= pd;
    beRedirect <= be;
    @(negedge clk);
    checkBit(cacheFlush, 1'b1, "cacheFlush with both redirects");
    idleCycle();
    exp = '{en: 1'b1, target: be.target};
    checkSquash(squash, exp, "backend redirect wins");
    checkPtr(tailPtr, advancePtr(be.fsqInfo.ptr), "tailPtr follows backend redirect");
endtask

task automatic commitRetire();
    fsqPkg::fetchStreamT s0;
    fsqPkg::fetchStreamT s1;
    fsqPkg::updateT exp;
    int off;
    applyReset();
    s0 = randomStream(2);
    s1 = randomStream(0);
    enqueueStream(s0);
    enqueueStream(s1);
    // newest instruction first, two lanes per cycle
    off = s0.size;
    while (off >= 0) begin
        driveCommit(ptrAt(0), off, off - 1);
        checkBit(update.en, 1'b0, "no update while stream is partial");
        off -= 2;
    end
    idleCycle();
    checkBit(update.en, 1'b0, "no update before retire edge");
    idleCycle();
    exp = '{en: 1'b1, startAddr: s0.startAddr, size: s0.size, mispredicted: 1'b0};
    checkUpdate(update, exp, "update for fully committed stream");
    off = 0;
    while (off <= s1.size) begin
        driveCommit(ptrAt(1), off, (off + 1 <= s1.size) ? off + 1 : -1);
        checkBit(update.en, 1'b0, "no update while second stream is partial");
        off += 2;
    end
    idleCycle();
    idleCycle();
    exp = '{en: 1'b1, startAddr: s1.startAddr, size: s1.size, mispredicted: 1'b0};
    checkUpdate(update, exp, "update for following stream");
endtask

task automatic mispredictRetire();
    fsqPkg::fetchStreamT s0;
    fsqPkg::redirectT be;
    fsqPkg::updateT exp;
    int k;
    applyReset();
    s0 = randomStream(2);
    enqueueStream(s0);
    k = $urandom % (s0.size + 1);
    be = '0;
    be.en = 1'b1;
    be.fsqInfo.ptr = ptrAt(0);
    be.fsqInfo.offset = fsqPkg::offsetWidth'(k);
    be.target = $urandom;
    @(posedge clk);
    predict.en <= 1'b0;
    beRedirect <= be;
    @(negedge clk);
    idleCycle();
    checkPtr(tailPtr, ptrAt(1), "tailPtr after backend redirect");
    driveCommit(ptrAt(0), k, -1);
    checkBit(update.en, 1'b0, "no update before mispredicted commit");
    idleCycle();
    checkBit(update.en, 1'b0, "no update before retire edge");
    idleCycle();
    exp = '{en: 1'b1, startAddr: s0.startAddr, size: s0.size, mispredicted: 1'b1};
    checkUpdate(update, exp, "update after mispredicted commit");
endtask

// ==== bench/fsqTb.sv ====
`timescale 1ns/1ps

module fsqTb;

    localparam int clkPeriod = 20;
    localparam int numTests = 6;
    localparam int cyclesPerTest = 200;

    logic clk;
    logic arstN;
    fsqPkg::predictT predict;
    logic predStall;
    fsqPkg::fsqPtrT tailPtr;
    fsqPkg::cacheReqT cacheReq;
    logic cacheReady;
    logic ibufFull;
    logic cacheFlush;
    fsqPkg::redirectT pdRedirect;
    fsqPkg::redirectT beRedirect;
    fsqPkg::commitSlotT [fsqPkg::commitWidth-1:0] commitBus;
    fsqPkg::squashT squash;
    fsqPkg::updateT update;

    int checks = 0;
    int errors = 0;

    fsqTop dut0 (
        .clk        (clk),
        .arstN      (arstN),
        .predict    (predict),
        .predStall  (predStall),
        .tailPtr    (tailPtr),
        .cacheReq   (cacheReq),
        .cacheReady (cacheReady),
        .ibufFull   (ibufFull),
        .cacheFlush (cacheFlush),
        .pdRedirect (pdRedirect),
        .beRedirect (beRedirect),
        .commitBus  (commitBus),
        .squash     (squash),
        .update     (update)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // watchdog
    initial begin
        repeat (numTests * cyclesPerTest) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles",
                 numTests * cyclesPerTest);
        $display(">>> FAIL");
        $finish;
    end

    task automatic checkCacheReq(input fsqPkg::cacheReqT got, input fsqPkg::cacheReqT exp,
                                 input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, cacheReq %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkSquash(input fsqPkg::squashT got, input fsqPkg::squashT exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, squash %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkUpdate(input fsqPkg::updateT got, input fsqPkg::updateT exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, update %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkPtr(input fsqPkg::fsqPtrT got, input fsqPkg::fsqPtrT exp,
                            input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, dir/idx %b/%0d expected %b/%0d",
                     $time, what, got.dir, got.idx, exp.dir, exp.idx);
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        arstN <= 1'b0;
        predict <= '0;
        cacheReady <= 1'b1;
        ibufFull <= 1'b0;
        pdRedirect <= '0;
        beRedirect <= '0;
        commitBus <= '0;
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkBit(predStall, 1'b0, "predStall after reset");
        checkBit(cacheReq.valid, 1'b0, "cacheReq valid after reset");
        checkBit(squash.en, 1'b0, "squash after reset");
        checkBit(update.en, 1'b0, "update after reset");
        checkPtr(tailPtr, '0, "tailPtr after reset");
    endtask

    `include "fsqTests.svh"

    initial begin
        arstN = 1'b0;
        predict = '0;
        cacheReady = 1'b1;
        ibufFull = 1'b0;
        pdRedirect = '0;
        beRedirect = '0;
        commitBus = '0;
        void'($urandom(79569));
        inOrderIssue();
        fullAndBackPressure();
        predecodeRedirect();
        redirectPriority();
        commitRetire();
        mispredictRetire();
        $display("fsqTb done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== src/fsqTop.sv ====
`timescale 1ns/1ps

module fsqTop (
    input  logic clk,
    input  logic arstN,
    input  fsqPkg::predictT predict,
    output logic predStall,
    output fsqPkg::fsqPtrT tailPtr,
    output fsqPkg::cacheReqT cacheReq,
    input  logic cacheReady,
    input  logic ibufFull,
    output logic cacheFlush,
    input  fsqPkg::redirectT pdRedirect,
    input  fsqPkg::redirectT beRedirect,
    input  fsqPkg::commitSlotT [fsqPkg::commitWidth-1:0] commitBus,
    output fsqPkg::squashT squash,
    output fsqPkg::updateT update
);

    fsqPkg::fsqPtrT searchPtr;
    fsqPkg::fsqPtrT commitPtr;
    fsqPkg::fetchStreamT searchStream;
    fsqPkg::fetchStreamT commitStream;
    logic enqueue;
    logic issueWant;
    logic issueFire;
    logic retire;

    fsqPointers pointers0 (
        .clk        (clk),
        .arstN      (arstN),
        .predict    (predict),
        .pdRedirect (pdRedirect),
        .beRedirect (beRedirect),
        .issueFire  (issueFire),
        .retire     (retire),
        .tailPtr    (tailPtr),
        .searchPtr  (searchPtr),
        .commitPtr  (commitPtr),
        .enqueue    (enqueue),
        .full       (predStall),
        .issueWant  (issueWant),
        .squash     (squash),
        .cacheFlush (cacheFlush)
    );

    streamStore store0 (
        .clk          (clk),
        .arstN        (arstN),
        .enqueue      (enqueue),
        .tailPtr      (tailPtr),
        .stream       (predict.stream),
        .searchPtr    (searchPtr),
        .commitPtr    (commitPtr),
        .searchStream (searchStream),
        .commitStream (commitStream)
    );

    fetchIssue issue0 (
        .clk          (clk),
        .arstN        (arstN),
        .issueWant    (issueWant),
        .searchPtr    (searchPtr),
        .searchStream (searchStream),
        .cacheReady   (cacheReady),
        .ibufFull     (ibufFull),
        .cacheReq     (cacheReq),
        .issueFire    (issueFire)
    );

    commitTracker commit0 (
        .clk          (clk),
        .arstN        (arstN),
        .commitBus    (commitBus),
        .beRedirect   (beRedirect),
        .commitPtr    (commitPtr),
        .tailPtr      (tailPtr),
        .commitStream (commitStream),
        .retire       (retire),
        .update       (update)
    );

endmodule

// ==== fsq/commitTracker.sv ====
`timescale 1ns/1ps

module commitTracker (
    input  logic clk,
    input  logic arstN,
    input  fsqPkg::commitSlotT [fsqPkg::commitWidth-1:0] commitBus,
    input  fsqPkg::redirectT beRedirect,
    input  fsqPkg::fsqPtrT commitPtr,
    input  fsqPkg::fsqPtrT tailPtr,
    input  fsqPkg::fetchStreamT commitStream,
    output logic retire,
    output fsqPkg::updateT update
);

    logic [1:0][fsqPkg::blockInstSize-1:0] commitVec;
    logic [1:0][fsqPkg::blockInstSize-1:0] commitSet;
    logic [fsqPkg::blockInstSize-1:0] mispredMask [fsqPkg::fsqSize];
    logic [fsqPkg::blockInstSize-1:0] headVec;
    logic [fsqPkg::blockInstSize-1:0] headMask;
    logic [fsqPkg::blockInstSize-1:0] reqMask;
    logic headRetire;
    logic updEn;
    logic [fsqPkg::vaddrSize-1:0] updStartAddr;
    logic [fsqPkg::offsetWidth-1:0] updSize;
    logic updMispred;

    // lanes merge into the bitmap picked by idx parity
    always_comb begin
        commitSet = '0;
        for (int i = 0; i < fsqPkg::commitWidth; i++) begin
            if (commitBus[i].en) begin
                commitSet[commitBus[i].fsqInfo.ptr.idx[0]][commitBus[i].fsqInfo.offset] = 1'b1;
            end
        end
    end

    // offsets 0..size must all commit
    always_comb begin
        for (int i = 0; i < fsqPkg::blockInstSize; i++) begin
            reqMask[i] = (i <= int'(commitStream.size));
        end
    end

    assign headVec = commitVec[commitPtr.idx[0]];
    assign headMask = mispredMask[commitPtr.idx];
    assign headRetire = ((headVec & reqMask) == reqMask) | (|(headVec & headMask));
    assign retire = (commitPtr != tailPtr) & headRetire;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            commitVec <= '0;
        end else begin
            commitVec <= commitVec | commitSet;
            if (retire) begin
                commitVec[commitPtr.idx[0]] <= '0;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mispredMask <= '{default: '0};
        end else begin
            if (retire) begin
                mispredMask[commitPtr.idx] <= '0;
            end
            // redirect of a younger stream lands after the clear
            if (beRedirect.en) begin
                mispredMask[beRedirect.fsqInfo.ptr.idx] <=
                    mispredMask[beRedirect.fsqInfo.ptr.idx] |
                    (fsqPkg::blockInstSize'(1) << beRedirect.fsqInfo.offset);
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            updEn <= 1'b0;
        end else begin
            updEn <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            updStartAddr <= commitStream.startAddr;
            updSize <= commitStream.size;
            updMispred <= |headMask;
        end
    end

    assign update = '{en: updEn, startAddr: updStartAddr, size: updSize,
                      mispredicted: updMispred};

endmodule

// ==== fsq/fetchIssue.sv ====
`timescale 1ns/1ps

module fetchIssue (
    input  logic clk,
    input  logic arstN,
    input  logic issueWant,
    input  fsqPkg::fsqPtrT searchPtr,
    input  fsqPkg::fetchStreamT searchStream,
    input  logic cacheReady,
    input  logic ibufFull,
    output fsqPkg::cacheReqT cacheReq,
    output logic issueFire
);

    logic loadOk;
    logic reqValid;
    fsqPkg::fsqPtrT reqPtr;
    fsqPkg::fetchStreamT reqStream;

    // cache can take a new request and ibuf has room
    assign loadOk = cacheReady & ~ibufFull;
    assign issueFire = loadOk & issueWant;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            reqValid <= 1'b0;
        end else if (loadOk) begin
            reqValid <= issueWant;
        end
    end

    // payload only changes when a real request is taken
    always_ff @(posedge clk) begin
        if (issueFire) begin
            reqPtr <= searchPtr;
            reqStream <= searchStream;
        end
    end

    assign cacheReq = '{valid: reqValid, ptr: reqPtr, stream: reqStream};

endmodule

// ==== fsq/streamStore.sv ====
`timescale 1ns/1ps

module streamStore (
    input  logic clk,
    input  logic arstN,
    input  logic enqueue,
    input  fsqPkg::fsqPtrT tailPtr,
    input  fsqPkg::fetchStreamT stream,
    input  fsqPkg::fsqPtrT searchPtr,
    input  fsqPkg::fsqPtrT commitPtr,
    output fsqPkg::fetchStreamT searchStream,
    output fsqPkg::fetchStreamT commitStream
);

    fsqPkg::fetchStreamT streams [fsqPkg::fsqSize];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            streams <= '{default: '0};
        end else if (enqueue) begin
            streams[tailPtr.idx] <= stream;
        end
    end

    // both heads read without a cycle of latency
    assign searchStream = streams[searchPtr.idx];
    assign commitStream = streams[commitPtr.idx];

endmodule

// ==== fsq/fsqPointers.sv ====
`timescale 1ns/1ps

module fsqPointers (
    input  logic clk,
    input  logic arstN,
    input  fsqPkg::predictT predict,
    input  fsqPkg::redirectT pdRedirect,
    input  fsqPkg::redirectT beRedirect,
    input  logic issueFire,
    input  logic retire,
    output fsqPkg::fsqPtrT tailPtr,
    output fsqPkg::fsqPtrT searchPtr,
    output fsqPkg::fsqPtrT commitPtr,
    output logic enqueue,
    output logic full,
    output logic issueWant,
    output fsqPkg::squashT squash,
    output logic cacheFlush
);

    fsqPkg::redirectT redirect;
    fsqPkg::fsqPtrT redirectNext;
    logic squashEn;
    logic [fsqPkg::vaddrSize-1:0] squashTarget;

    // backend wins over predecode
    assign redirect = beRedirect.en ? beRedirect : pdRedirect;
    assign redirectNext = fsqPkg::fsqPtrInc(redirect.fsqInfo.ptr);

    // same slot, different lap
    assign full = (tailPtr.idx == commitPtr.idx) && (tailPtr.dir != commitPtr.dir);
    assign enqueue = predict.en & ~full;
    assign cacheFlush = pdRedirect.en | beRedirect.en;
    assign issueWant = (searchPtr != tailPtr) & ~cacheFlush;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            tailPtr <= '0;
        end else if (redirect.en) begin
            tailPtr <= redirectNext;
        end else if (enqueue) begin
            tailPtr <= fsqPkg::fsqPtrInc(tailPtr);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            searchPtr <= '0;
        end else if (redirect.en) begin
            searchPtr <= redirectNext;
        end else if (issueFire) begin
            searchPtr <= fsqPkg::fsqPtrInc(searchPtr);
        end
    end

    // commit head only moves forward
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            commitPtr <= '0;
        end else if (retire) begin
            commitPtr <= fsqPkg::fsqPtrInc(commitPtr);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            squashEn <= 1'b0;
        end else begin
            squashEn <= redirect.en;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect.en) begin
            squashTarget <= redirect.target;
        end
    end

    assign squash = '{en: squashEn, target: squashTarget};

endmodule

// ==== common/fsqPkg.sv ====
package fsqPkg;

    localparam int fsqSize = 16;
    localparam int fsqWidth = 4;
    localparam int blockInstSize = 8;
    localparam int offsetWidth = 3;
    localparam int commitWidth = 2;
    localparam int vaddrSize = 32;

    // dir sits above idx so a plain +1 toggles it on wrap
    typedef struct packed {
        logic dir;
        logic [fsqWidth-1:0] idx;
    } fsqPtrT;

    // size is instruction count minus one
    typedef struct packed {
        logic [vaddrSize-1:0] startAddr;
        logic [offsetWidth-1:0] size;
    } fetchStreamT;

    typedef struct packed {
        fsqPtrT ptr;
        logic [offsetWidth-1:0] offset;
    } fsqInfoT;

    typedef struct packed {
        logic en;
        fetchStreamT stream;
    } predictT;

    typedef struct packed {
        logic valid;
        fsqPtrT ptr;
        fetchStreamT stream;
    } cacheReqT;

    typedef struct packed {
        logic en;
        fsqInfoT fsqInfo;
        logic [vaddrSize-1:0] target;
    } redirectT;

    typedef struct packed {
        logic en;
        fsqInfoT fsqInfo;
    } commitSlotT;

    typedef struct packed {
        logic en;
        logic [vaddrSize-1:0] target;
    } squashT;

    typedef struct packed {
        logic en;
        logic [vaddrSize-1:0] startAddr;
        logic [offsetWidth-1:0] size;
        logic mispredicted;
    } updateT;

    // next queue slot, direction flips when idx wraps
    function automatic fsqPtrT fsqPtrInc(input fsqPtrT ptr);
        fsqPtrT nextPtr;
        nextPtr = fsqPtrT'(ptr + 1'b1);
        return nextPtr;
    endfunction

endpackage
